//--- list.f
+incdir+tb
verilog/seq_pkg.sv
verilog/seq_step_engine.sv
verilog/seq_axil_regs.sv
verilog/programmable_sequencer.sv
tb/programmable_sequencer_tb.sv

//--- run.sh
#!/bin/sh
# Builds the step sequencer testbench with Verilator and runs it into sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module programmable_sequencer_tb \
    -f list.f --Mdir obj_dir -o sim_programmable_sequencer

# A $fatal stop gives a non-zero exit, the log is searched instead
./obj_dir/sim_programmable_sequencer > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

//--- tb/axil_master_tasks.svh
/*
 * AXI4-Lite master tasks for the sequencer testbench
 * One transfer at a time with random back-pressure on bready and rready
 */

// Single word write that waits for the handshake and then takes the response
task automatic axil_write(input seq_pkg::axil_addr_t addr, input seq_pkg::axil_data_t data);
    int unsigned hold;
    hold    = $urandom % 4;
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    // Ready is registered, so once it is seen the next edge takes the write
    while (!awready) begin
        next_cycle();
    end
    check_value("wready with awready", 1, 32'(wready));
    next_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    // The response has to stay valid while bready is held off
    repeat (hold) next_cycle();
    check_value("bvalid held", 1, 32'(bvalid));
    check_value("bresp", 0, 32'(bresp));
    bready = 1'b1;
    next_cycle();
    bready = 1'b0;
endtask

// Single word read, data is taken on the cycle rready is raised
task automatic axil_read(input seq_pkg::axil_addr_t addr, output seq_pkg::axil_data_t data);
    int unsigned hold;
    hold    = $urandom % 4;
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) begin
        next_cycle();
    end
    next_cycle();
    arvalid = 1'b0;
    repeat (hold) next_cycle();
    check_value("rvalid held", 1, 32'(rvalid));
    check_value("rresp", 0, 32'(rresp));
    data   = rdata;
    rready = 1'b1;
    next_cycle();
    rready = 1'b0;
endtask

//--- tb/programmable_sequencer_tb.sv
/*
 * Testbench of the programmable step sequencer
 * Random configuration over AXI4-Lite, a random step responder and a model
 * that checks step order, gap timing, repeat mode and register readback
 */
`default_nettype none

module programmable_sequencer_tb;

    localparam int NUM_PASSES = 12;
    localparam int MAX_GAP    = 5;
    // Single passes, the empty pass and three repeat passes, plus bus traffic
    localparam int WATCHDOG_CYCLES =
        (NUM_PASSES + 4) * (seq_pkg::MAX_STEPS * (MAX_GAP + 10) + 150) + 2000;

    logic clk;
    logic arst_n;
    seq_pkg::axil_addr_t awaddr, araddr;
    seq_pkg::axil_data_t wdata, rdata;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic enable, busy;
    seq_pkg::step_mask_t step_start;
    seq_pkg::step_mask_t step_done = '0;

    // Counts rising edges and is the time base of every timing check
    int edge_cnt = 0;
    // What the responder saw with one entry per step
    int pulse_edges[$];
    int pulse_masks[$];
    int pulse_short[$];
    int done_edges[$];
    // Model of the configuration last written
    int exp_table[seq_pkg::MAX_STEPS];
    int exp_count;
    int exp_gap;

    programmable_sequencer DUT (
        .clk(clk), .arst_n(arst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .enable(enable), .step_done(step_done), .step_start(step_start), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Inputs change one time unit after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    `include "axil_master_tasks.svh"

    // Answers each start pulse after 1 to 6 cycles and sometimes first with a wrong mask
    always begin : step_responder
        int unsigned delay;
        seq_pkg::step_mask_t mask;
        next_cycle();
        if (step_start != '0) begin
            mask = step_start;
            pulse_edges.push_back(edge_cnt);
            pulse_masks.push_back(int'(mask));
            next_cycle();
            pulse_short.push_back(int'(step_start == '0));
            delay = 1 + $urandom % 6;
            repeat (delay - 1) next_cycle();
            if ($urandom % 2 == 1) begin
                step_done = seq_pkg::step_mask_t'($urandom) & ~mask;
                next_cycle();
            end
            step_done = mask | seq_pkg::step_mask_t'($urandom);
            done_edges.push_back(edge_cnt + 1);
            next_cycle();
            step_done = '0;
        end
    end

    // Writes gap, a random table and control, and updates the model
    task automatic configure(input int count_field, input bit rep, input int gap);
        seq_pkg::axil_data_t slot_word;
        axil_write(seq_pkg::REG_GAP, 32'(gap));
        for (int k = 0; k < seq_pkg::MAX_STEPS; k++) begin
            slot_word    = $urandom;
            exp_table[k] = int'(slot_word & 32'h7);
            axil_write(seq_pkg::REG_SLOT0 + 8'(4 * k), slot_word);
        end
        axil_write(seq_pkg::REG_CTRL, 32'(count_field) | (32'(rep) << 8));
        exp_gap   = gap;
        exp_count = (count_field > seq_pkg::MAX_STEPS) ? seq_pkg::MAX_STEPS : count_field;
    endtask

    task automatic pulse_enable(output int sample_edge);
        enable      = 1'b1;
        sample_edge = edge_cnt + 1;
        next_cycle();
        enable = 1'b0;
    endtask

    // Compares the steps seen since entry first with the model
    task automatic check_run(input int first, input int en_edge, input int passes,
                             input int idle_edge);
        int slot;
        int ref_edge;
        check_value("number of steps", passes * exp_count, pulse_edges.size() - first);
        for (int i = first; i < pulse_edges.size(); i++) begin
            slot     = (i - first) % exp_count;
            ref_edge = (i == first) ? en_edge : done_edges[i - 1];
            check_value("step one-hot", 1 << exp_table[slot], pulse_masks[i]);
            check_value("step gap timing", ref_edge + exp_gap + 1, pulse_edges[i]);
            check_value("step pulse width", 1, pulse_short[i]);
        end
        // Busy falls on the edge right after the last done
        check_value("busy fall", done_edges[done_edges.size() - 1], idle_edge);
    endtask

    task automatic register_readback_test();
        seq_pkg::axil_data_t ctrl_val, gap_val, got;
        seq_pkg::axil_data_t slot_val[seq_pkg::MAX_STEPS];
        seq_pkg::axil_addr_t addr;
        ctrl_val = $urandom;
        gap_val  = $urandom;
        axil_write(seq_pkg::REG_CTRL, ctrl_val);
        axil_write(seq_pkg::REG_GAP, gap_val);
        axil_write(seq_pkg::REG_STATUS, $urandom);
        for (int k = 0; k < seq_pkg::MAX_STEPS; k++) begin
            slot_val[k] = $urandom;
            axil_write(seq_pkg::REG_SLOT0 + 8'(4 * k), slot_val[k]);
        end
        // Count in bits 3:0 and repeat in bit 8
        axil_read(seq_pkg::REG_CTRL, got);
        check_value("ctrl readback", ctrl_val & 32'h0000_010f, got);
        axil_read(seq_pkg::REG_GAP, got);
        check_value("gap readback", gap_val, got);
        for (int k = 0; k < seq_pkg::MAX_STEPS; k++) begin
            axil_read(seq_pkg::REG_SLOT0 + 8'(4 * k), got);
            check_value("slot readback", slot_val[k] & 32'h7, got);
        end
        // Nothing has run since reset, so busy and the slot field are both still 0
        axil_read(seq_pkg::REG_STATUS, got);
        check_value("status while idle", 0, got);
        for (int k = 0; k < 4; k++) begin
            addr = 8'(8'h2C + 4 * ($urandom % 53));
            axil_read(addr, got);
            check_value("unmapped readback", 0, got);
        end
    endtask

    task automatic single_pass_test(input int count_field);
        int first;
        int en_edge;
        configure(count_field, 1'b0, $urandom % (MAX_GAP + 1));
        first = pulse_edges.size();
        pulse_enable(en_edge);
        check_value("busy after enable", 1, 32'(busy));
        while (busy) next_cycle();
        check_run(first, en_edge, 1, edge_cnt);
    endtask

    task automatic zero_count_test();
        int first;
        int en_edge;
        configure(0, 1'b0, $urandom % (MAX_GAP + 1));
        first = pulse_edges.size();
        pulse_enable(en_edge);
        repeat (MAX_GAP + 20) next_cycle();
        check_value("steps with count 0", 0, pulse_edges.size() - first);
        check_value("busy with count 0", 0, 32'(busy));
    endtask

    // Two full passes run back to back, then repeat is cleared during the third
    task automatic repeat_test();
        int count_field;
        int first;
        int en_edge;
        int ignored_edge;
        seq_pkg::axil_data_t status;
        count_field = 3 + $urandom % 6;
        configure(count_field, 1'b1, 2 + $urandom % 4);
        first = pulse_edges.size();
        pulse_enable(en_edge);
        // Slot 0 is still waiting out its gap when the status word is taken
        axil_read(seq_pkg::REG_STATUS, status);
        check_value("status while running", 32'h1, status);
        // A second enable while busy must not restart the pass
        pulse_enable(ignored_edge);
        while (done_edges.size() - first < 2 * exp_count) next_cycle();
        axil_write(seq_pkg::REG_CTRL, 32'(count_field));
        while (busy) next_cycle();
        check_run(first, en_edge, 3, edge_cnt);
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Testbench failed");
        $fatal(1, "Run stopped by the watchdog");
    end

    initial begin : main_sequence
        void'($urandom(32'hfa5c));
        arst_n  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        enable  = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        next_cycle();
        register_readback_test();
        // Every fourth pass uses a count above the table size
        for (int i = 0; i < NUM_PASSES; i++) begin
            if (i % 4 == 3) begin
                single_pass_test(9 + $urandom % 7);
            end else begin
                single_pass_test(1 + $urandom % 8);
            end
        end
        zero_count_test();
        repeat_test();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/programmable_sequencer.sv
/*
 * Programmable step sequencer, top level
 * AXI4-Lite configured table of up to eight steps run by the step engine
 */
`default_nettype none

module programmable_sequencer (
    input  wire logic                               clk,
    input  wire logic                               arst_n,
    // AXI4-Lite slave port
    input  wire seq_pkg::axil_addr_t                awaddr,
    input  wire logic                               awvalid,
    output logic                                    awready,
    input  wire seq_pkg::axil_data_t                wdata,
    input  wire logic [seq_pkg::AXIL_DATA_W/8-1:0]  wstrb,
    input  wire logic                               wvalid,
    output logic                                    wready,
    output logic [1:0]                              bresp,
    output logic                                    bvalid,
    input  wire logic                               bready,
    input  wire seq_pkg::axil_addr_t                araddr,
    input  wire logic                               arvalid,
    output logic                                    arready,
    output seq_pkg::axil_data_t                     rdata,
    output logic [1:0]                              rresp,
    output logic                                    rvalid,
    input  wire logic                               rready,
    // Step lines
    input  wire logic                               enable,
    input  wire seq_pkg::step_mask_t                step_done,
    output seq_pkg::step_mask_t                     step_start,
    output logic                                    busy
);

    // Configuration from the registers
    seq_pkg::step_count_t seq_count;
    logic                 repeat_en;
    seq_pkg::gap_t        gap_cycles;
    seq_pkg::step_table_t step_table;
    // Progress reported back for the status register
    seq_pkg::step_idx_t   cur_slot;

    seq_axil_regs u_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .busy       (busy),
        .cur_slot   (cur_slot),
        .seq_count  (seq_count),
        .repeat_en  (repeat_en),
        .gap_cycles (gap_cycles),
        .step_table (step_table)
    );

    seq_step_engine u_engine (
        .clk        (clk),
        .arst_n     (arst_n),
        .enable     (enable),
        .step_done  (step_done),
        .seq_count  (seq_count),
        .repeat_en  (repeat_en),
        .gap_cycles (gap_cycles),
        .step_table (step_table),
        .step_start (step_start),
        .busy       (busy),
        .cur_slot   (cur_slot)
    );

endmodule

`default_nettype wire

//--- verilog/seq_axil_regs.sv
/*
 * AXI4-Lite register block of the step sequencer
 * Holds count, repeat, gap and the step table, and reads back engine status
 * One write and one read may be outstanding, each on its own channel
 */
`default_nettype none

module seq_axil_regs (
    input  wire logic                                clk,
    input  wire logic                                arst_n,
    // Write address and data channels
    input  wire seq_pkg::axil_addr_t                 awaddr,
    input  wire logic                                awvalid,
    output logic                                     awready,
    input  wire seq_pkg::axil_data_t                 wdata,
    input  wire logic [seq_pkg::AXIL_DATA_W/8-1:0]   wstrb,
    input  wire logic                                wvalid,
    output logic                                     wready,
    // Write response channel
    output logic [1:0]                               bresp,
    output logic                                     bvalid,
    input  wire logic                                bready,
    // Read address and data channels
    input  wire seq_pkg::axil_addr_t                 araddr,
    input  wire logic                                arvalid,
    output logic                                     arready,
    output seq_pkg::axil_data_t                      rdata,
    output logic [1:0]                               rresp,
    output logic                                     rvalid,
    input  wire logic                                rready,
    // Engine status
    input  wire logic                                busy,
    input  wire seq_pkg::step_idx_t                  cur_slot,
    // Configuration towards the engine
    output seq_pkg::step_count_t                     seq_count,
    output logic                                     repeat_en,
    output seq_pkg::gap_t                            gap_cycles,
    output seq_pkg::step_table_t                     step_table
);

    // Shared ready for the address and data halves of a write
    logic                wr_ready;
    logic                wr_fire;
    logic                rd_fire;
    seq_pkg::axil_data_t rd_word;

    // True for a word aligned offset inside the slot window
    function automatic logic is_slot(input seq_pkg::axil_addr_t addr);
        return (addr >= seq_pkg::REG_SLOT0) && (addr <= seq_pkg::REG_SLOT_LAST) &&
               (addr[1:0] == 2'b00);
    endfunction

    // Slot number addressed by an offset in the slot window
    function automatic seq_pkg::step_idx_t slot_of(input seq_pkg::axil_addr_t addr);
        seq_pkg::axil_addr_t offset;
        offset = addr - seq_pkg::REG_SLOT0;
        return offset[seq_pkg::STEP_IDX_W+1:2];
    endfunction

    assign awready = wr_ready;
    assign wready  = wr_ready;
    assign bresp   = seq_pkg::AXIL_RESP_OKAY;
    assign rresp   = seq_pkg::AXIL_RESP_OKAY;

    // The register is updated on the edge that ends the ready pulse
    assign wr_fire = wr_ready && awvalid && wvalid;
    assign rd_fire = arready && arvalid;

    // Write channel handshake
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            // Ready is a single cycle pulse and stays low while a response is pending
            wr_ready <= awvalid && wvalid && !wr_ready && !bvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Configuration registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seq_count  <= '0;
            repeat_en  <= 1'b0;
            gap_cycles <= '0;
            step_table <= '0;
        end else if (wr_fire) begin
            // Byte strobes are not looked at, every write replaces the whole word
            case (awaddr)
                seq_pkg::REG_CTRL: begin
                    seq_count <= wdata[seq_pkg::COUNT_W-1:0];
                    repeat_en <= wdata[seq_pkg::CTRL_REPEAT_BIT];
                end
                seq_pkg::REG_GAP: begin
                    gap_cycles <= wdata;
                end
                seq_pkg::REG_STATUS: begin
                    // Status is read only so the write just completes
                end
                default: begin
                    // Only the low bits of a slot word name a step
                    if (is_slot(awaddr)) begin
                        step_table[slot_of(awaddr)*seq_pkg::STEP_IDX_W +: seq_pkg::STEP_IDX_W]
                            <= wdata[seq_pkg::STEP_IDX_W-1:0];
                    end
                end
            endcase
        end
    end

    // Readback mux, unmapped offsets give zero
    always_comb begin
        rd_word = '0;
        case (araddr)
            seq_pkg::REG_CTRL: begin
                rd_word[seq_pkg::COUNT_W-1:0]       = seq_count;
                rd_word[seq_pkg::CTRL_REPEAT_BIT]   = repeat_en;
            end
            seq_pkg::REG_STATUS: begin
                rd_word[0] = busy;
                rd_word[seq_pkg::STATUS_SLOT_LSB +: seq_pkg::STEP_IDX_W] = cur_slot;
            end
            seq_pkg::REG_GAP: begin
                rd_word = gap_cycles;
            end
            default: begin
                if (is_slot(araddr)) begin
                    rd_word[seq_pkg::STEP_IDX_W-1:0] =
                        step_table[slot_of(araddr)*seq_pkg::STEP_IDX_W +: seq_pkg::STEP_IDX_W];
                end
            end
        endcase
    end

    // Read channel handshake
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            // No new address is taken until the previous data has been consumed
            arready <= arvalid && !arready && !rvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Read data is captured with the address and held with rvalid
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

//--- verilog/seq_step_engine.sv
/*
 * Step sequencer engine
 * Walks the step table slot by slot, waits out the gap before each step,
 * pulses its start line and holds until the matching done bit is seen
 */
`default_nettype none

module seq_step_engine (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  enable,
    input  wire seq_pkg::step_mask_t   step_done,
    input  wire seq_pkg::step_count_t  seq_count,
    input  wire logic                  repeat_en,
    input  wire seq_pkg::gap_t         gap_cycles,
    input  wire seq_pkg::step_table_t  step_table,
    output seq_pkg::step_mask_t        step_start,
    output logic                       busy,
    output seq_pkg::step_idx_t         cur_slot
);

    seq_pkg::engine_state_t state;
    // Gap cycles still to wait before the current slot is issued
    seq_pkg::gap_t          gap_cnt;
    seq_pkg::step_idx_t     slot;
    // One-hot of the step in flight, used to filter done bits
    seq_pkg::step_mask_t    cur_mask;
    seq_pkg::step_count_t   eff_count;
    seq_pkg::step_idx_t     slot_step;
    seq_pkg::step_mask_t    issue_mask;
    logic                   last_slot;
    logic                   done_hit;

    always_comb begin
        // Counts above the table size run the whole table
        if (seq_count > seq_pkg::step_count_t'(seq_pkg::MAX_STEPS)) begin
            eff_count = seq_pkg::step_count_t'(seq_pkg::MAX_STEPS);
        end else begin
            eff_count = seq_count;
        end

        // The step number is looked up only while the slot is being issued
        slot_step  = step_table[slot*seq_pkg::STEP_IDX_W +: seq_pkg::STEP_IDX_W];
        issue_mask = seq_pkg::step_mask_t'(1) << slot_step;

        // The count is checked again at the end of each pass
        last_slot = (seq_pkg::step_count_t'(slot) + seq_pkg::step_count_t'(1)) >= eff_count;

        // Bits of other steps are ignored
        done_hit = |(step_done & cur_mask);
    end

    // Start line of the current step is high only for the single issue cycle
    assign step_start = (state == seq_pkg::ST_START) ? issue_mask : '0;
    assign busy       = (state != seq_pkg::ST_IDLE);
    assign cur_slot   = slot;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= seq_pkg::ST_IDLE;
            gap_cnt <= '0;
            slot    <= '0;
        end else begin
            case (state)
                seq_pkg::ST_IDLE: begin
                    // An empty table never leaves idle
                    if (enable && (eff_count != '0)) begin
                        state   <= seq_pkg::ST_GAP;
                        gap_cnt <= gap_cycles;
                        slot    <= '0;
                    end
                end
                seq_pkg::ST_GAP: begin
                    // A loaded value of g keeps this state for g+1 cycles
                    if (gap_cnt == '0) begin
                        state <= seq_pkg::ST_START;
                    end else begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
                seq_pkg::ST_START: begin
                    state <= seq_pkg::ST_WAIT;
                end
                seq_pkg::ST_WAIT: begin
                    if (done_hit) begin
                        if (!last_slot) begin
                            state   <= seq_pkg::ST_GAP;
                            gap_cnt <= gap_cycles;
                            slot    <= slot + 1'b1;
                        end else if (repeat_en && (eff_count != '0)) begin
                            // Next pass follows straight away with the same gap rule
                            state   <= seq_pkg::ST_GAP;
                            gap_cnt <= gap_cycles;
                            slot    <= '0;
                        end else begin
                            state <= seq_pkg::ST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= seq_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Remember which step was issued so that later table writes cannot confuse the match
    always_ff @(posedge clk) begin
        if (state == seq_pkg::ST_START) begin
            cur_mask <= issue_mask;
        end
    end

endmodule

`default_nettype wire

//--- verilog/seq_pkg.sv
/*
 * Step sequencer shared definitions
 * Sizes, vector types, the register map and the engine state encoding
 */
`default_nettype none

package seq_pkg;

    // Number of step lines and of table slots
    localparam int MAX_STEPS     = 8;
    localparam int STEP_IDX_W    = 3;
    localparam int COUNT_W       = $clog2(MAX_STEPS + 1);
    localparam int COUNTER_WIDTH = 32;
    localparam int AXIL_ADDR_W   = 8;
    localparam int AXIL_DATA_W   = 32;

    typedef logic [MAX_STEPS-1:0]            step_mask_t;
    typedef logic [STEP_IDX_W-1:0]           step_idx_t;
    typedef logic [COUNT_W-1:0]              step_count_t;
    typedef logic [MAX_STEPS*STEP_IDX_W-1:0] step_table_t;
    typedef logic [COUNTER_WIDTH-1:0]        gap_t;
    typedef logic [AXIL_ADDR_W-1:0]          axil_addr_t;
    typedef logic [AXIL_DATA_W-1:0]          axil_data_t;

    // Byte offsets of the register map
    localparam axil_addr_t REG_CTRL      = 8'h00;
    localparam axil_addr_t REG_STATUS    = 8'h04;
    localparam axil_addr_t REG_GAP       = 8'h08;
    localparam axil_addr_t REG_SLOT0     = 8'h0C;
    localparam axil_addr_t REG_SLOT_LAST = 8'h28;

    // Field positions inside the control and status words
    localparam int CTRL_REPEAT_BIT = 8;
    localparam int STATUS_SLOT_LSB = 4;

    localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_GAP,
        ST_START,
        ST_WAIT
    } engine_state_t;

endpackage

`default_nettype wire
